// ==== source/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath and address width
`define XLEN 32

// Register file geometry
`define REG_COUNT 8
`define REG_AW 3
// esi holds the base address of every memory access
`define ESI_INDEX 6

// Immediate of the register-constant forms
`define RI_CONST 10

// Opcode byte values
`define OP_LOAD 8'h8B
`define OP_STORE_MOVE 8'h89
`define OP_ADD 8'h01
`define OP_SUB 8'h29
`define OP_RI 8'h83
`define OP_HALT 8'hF4

// Mod field of the modrm byte
`define MOD_MEM 2'd1
`define MOD_REG 2'd3

// modrm bits 7..3 selecting add or sub for opcode 83
`define RI_ADD_MOD 5'd24
`define RI_SUB_MOD 5'd29

`endif

// ==== source/cpu_pkg.sv ====
`include "cpu_settings.svh"

package cpu_pkg;

  // Machine word and register index
  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_AW-1:0] reg_idx_t;

  // Operation class, NONE covers every unknown opcode
  typedef enum logic [3:0] {
    NONE,
    LOAD,
    STORE,
    MOVE,
    ADD,
    SUB,
    RI_ADD,
    RI_SUB,
    HALT
  } op_class_e;

  // Result of a single decode, carried down the pipe
  typedef struct packed {
    logic [7:0] opcode;
    op_class_e  op;
    reg_idx_t   rd;
    reg_idx_t   rs;
    // esi for memory ops, rd otherwise
    reg_idx_t   a_idx;
    word_t      disp;
    logic [1:0] len;
  } decoded_t;

endpackage

// ==== source/cpu_ifs.sv ====
`timescale 1ns/1ps

// Operand read path, execute stage to register file
interface regfile_read_if import cpu_pkg::*; ();
  reg_idx_t a_idx;
  reg_idx_t b_idx;
  word_t    a_data;
  word_t    b_data;

  // Execute side selects the registers
  modport reader (output a_idx, output b_idx, input a_data, input b_data);
  // Register file answers combinationally
  modport source (input a_idx, input b_idx, output a_data, output b_data);
endinterface

// Execute stage results handed to the memory stage
interface ex_mem_if import cpu_pkg::*; ();
  decoded_t op;
  // Memory address
  word_t    mar;
  // ALU or move result
  word_t    c;
  // Store data
  word_t    mdr_w;

  modport producer (output op, output mar, output c, output mdr_w);
  modport consumer (input op, input mar, input c, input mdr_w);
endinterface

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module instr_decoder import cpu_pkg::*; (
  input  word_t    word,
  output decoded_t dec
);

  logic [7:0] opcode;
  logic [1:0] mod_field;
  logic [4:0] ri_mod;
  logic       is_mem;
  op_class_e  op;

  // Byte 0 opcode, byte 1 modrm
  assign opcode = word[7:0];
  assign mod_field = word[15:14];
  // RI forms use modrm bits 7..3 as sub-opcode
  assign ri_mod = word[15:11];

  always_comb begin
    op = NONE;
    if (opcode == `OP_LOAD && mod_field == `MOD_MEM) op = LOAD;
    else if (opcode == `OP_STORE_MOVE && mod_field == `MOD_MEM) op = STORE;
    else if (opcode == `OP_STORE_MOVE && mod_field == `MOD_REG) op = MOVE;
    else if (opcode == `OP_ADD) op = ADD;
    else if (opcode == `OP_SUB) op = SUB;
    else if (opcode == `OP_RI && ri_mod == `RI_ADD_MOD) op = RI_ADD;
    else if (opcode == `OP_RI && ri_mod == `RI_SUB_MOD) op = RI_SUB;
    else if (opcode == `OP_HALT) op = HALT;
  end

  assign is_mem = (op == LOAD) || (op == STORE);

  always_comb begin
    dec.opcode = opcode;
    dec.op = op;
    dec.rd = word[10:8];
    dec.rs = word[13:11];
    // Memory ops address through esi
    dec.a_idx = is_mem ? reg_idx_t'(`ESI_INDEX) : word[10:8];
    // Byte 2, sign extended
    dec.disp = {{(`XLEN-8){word[23]}}, word[23:16]};
    case (op)
      LOAD, STORE: dec.len = 2'd3;
      MOVE, ADD, SUB, RI_ADD, RI_SUB: dec.len = 2'd2;
      default: dec.len = 2'd1;
    endcase
  end

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  word_t bus_in_ins,
  output word_t bus_a_ins,
  output word_t ir
);

  word_t    ip;
  decoded_t pre;

  // Length and halt come straight off the instruction bus
  instr_decoder u_predec (
    .word (bus_in_ins),
    .dec  (pre)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ip <= '0;
      ir <= '0;
    end else begin
      ir <= bus_in_ins;
      // Halt parks the pointer on itself
      if (pre.op != HALT)
        ip <= ip + word_t'(pre.len);
    end
  end

  assign bus_a_ins = ip;

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module register_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  regfile_read_if.source rd_port,
  input  logic     we,
  input  reg_idx_t w_idx,
  input  word_t    w_data
);

  // eax .. edi
  word_t regs [`REG_COUNT];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end else if (we) begin
      regs[w_idx] <= w_data;
    end
  end

  // Both read ports are asynchronous
  assign rd_port.a_data = regs[rd_port.a_idx];
  assign rd_port.b_data = regs[rd_port.b_idx];

endmodule

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_unit import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  decoded_t dec,
  regfile_read_if.reader rd_port,
  ex_mem_if.producer     ex
);

  decoded_t dec_q;
  word_t    a_op;
  word_t    b_op;
  word_t    alu_y;

  // Decode stage register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) dec_q <= '0;
    else dec_q <= dec;
  end

  // Operand fetch, A from esi or rd, B always from rs
  assign rd_port.a_idx = dec_q.a_idx;
  assign rd_port.b_idx = dec_q.rs;
  assign a_op = rd_port.a_data;
  assign b_op = rd_port.b_data;

  always_comb begin
    case (dec_q.op)
      // Effective address
      LOAD, STORE: alu_y = a_op + dec_q.disp;
      SUB: alu_y = a_op - b_op;
      RI_ADD: alu_y = a_op + word_t'(`RI_CONST);
      RI_SUB: alu_y = a_op - word_t'(`RI_CONST);
      default: alu_y = a_op + b_op;
    endcase
  end

  // Execute stage, op and address bus cleared on reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ex.op <= '0;
      ex.mar <= '0;
    end else begin
      ex.op <= dec_q;
      ex.mar <= alu_y;
    end
  end

  always_ff @(posedge clk) begin
    // Move bypasses the ALU
    ex.c <= (dec_q.op == MOVE) ? b_op : alu_y;
    ex.mdr_w <= b_op;
  end

endmodule

// ==== source/mem_wb_unit.sv ====
`timescale 1ns/1ps

module mem_wb_unit import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  ex_mem_if.consumer ex,
  input  word_t      bus_in_data,
  output word_t      bus_a_data,
  output word_t      bus_out,
  output logic       bus_we,
  output logic       bus_re_data,
  output logic       we,
  output reg_idx_t   w_idx,
  output word_t      w_data,
  output logic [7:0] current_opcode
);

  decoded_t wb_op;
  word_t    wb_c;
  word_t    wb_mdr_r;

  // Memory stage bus drive
  assign bus_a_data = ex.mar;
  assign bus_re_data = (ex.op.op == LOAD);
  assign bus_we = (ex.op.op == STORE);
  assign bus_out = ex.mdr_w;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) wb_op <= '0;
    else wb_op <= ex.op;
  end

  always_ff @(posedge clk) begin
    wb_c <= ex.c;
    // Read data only latched for loads
    if (bus_re_data)
      wb_mdr_r <= bus_in_data;
  end

  // Write-back port, load targets rs and everything else rd
  assign we = wb_op.op inside {LOAD, MOVE, ADD, SUB, RI_ADD, RI_SUB};
  assign w_idx = (wb_op.op == LOAD) ? wb_op.rs : wb_op.rd;
  assign w_data = (wb_op.op == LOAD) ? wb_mdr_r : wb_c;

  assign current_opcode = wb_op.opcode;

endmodule

// ==== source/cisc_cpu_top.sv ====
`timescale 1ns/1ps

module cisc_cpu_top import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // Instruction bus
  output word_t      bus_a_ins,
  input  word_t      bus_in_ins,
  // Data bus
  output word_t      bus_a_data,
  input  word_t      bus_in_data,
  output word_t      bus_out,
  output logic       bus_we,
  output logic       bus_re_data,
  // Opcode now in write-back
  output logic [7:0] current_opcode
);

  word_t    ir;
  decoded_t dec;
  logic     rf_we;
  reg_idx_t rf_w_idx;
  word_t    rf_w_data;

  regfile_read_if rf_rd ();
  ex_mem_if       ex_mem ();

  // IF stage
  fetch_unit u_fetch (
    .clk        (clk),
    .rst        (rst),
    .bus_in_ins (bus_in_ins),
    .bus_a_ins  (bus_a_ins),
    .ir         (ir)
  );

  // Single decode of the fetched word
  instr_decoder u_dec (
    .word (ir),
    .dec  (dec)
  );

  // DEC and EXE stages
  execute_unit u_exec (
    .clk     (clk),
    .rst     (rst),
    .dec     (dec),
    .rd_port (rf_rd.reader),
    .ex      (ex_mem.producer)
  );

  register_file u_rf (
    .clk     (clk),
    .rst     (rst),
    .rd_port (rf_rd.source),
    .we      (rf_we),
    .w_idx   (rf_w_idx),
    .w_data  (rf_w_data)
  );

  // MEM and WB stages
  mem_wb_unit u_mem_wb (
    .clk            (clk),
    .rst            (rst),
    .ex             (ex_mem.consumer),
    .bus_in_data    (bus_in_data),
    .bus_a_data     (bus_a_data),
    .bus_out        (bus_out),
    .bus_we         (bus_we),
    .bus_re_data    (bus_re_data),
    .we             (rf_we),
    .w_idx          (rf_w_idx),
    .w_data         (rf_w_data),
    .current_opcode (current_opcode)
  );

endmodule

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

  localparam int RST_CYCLES = 3;

  logic        clk;
  logic        rst;
  logic [31:0] bus_a_ins;
  logic [31:0] bus_in_ins;
  logic [31:0] bus_a_data;
  logic [31:0] bus_in_data;
  logic [31:0] bus_out;
  logic        bus_we;
  logic        bus_re_data;
  logic [7:0]  current_opcode;

  // Program bytes and data words by address
  logic [7:0]  imem [0:255];
  logic [31:0] dmem [logic [31:0]];
  // Expected traces from the test file
  logic [31:0] exp_ia [$];
  logic [31:0] exp_ld [$];
  logic [31:0] exp_st_a [$];
  logic [31:0] exp_st_v [$];
  logic [31:0] last_ia;
  logic        halted;
  int          ai;
  int          li;
  int          si;
  int          prog_bytes;
  int          cycles;
  int          limit;

  cisc_cpu_top UUT (
    .clk            (clk),
    .rst            (rst),
    .bus_a_ins      (bus_a_ins),
    .bus_in_ins     (bus_in_ins),
    .bus_a_data     (bus_a_data),
    .bus_in_data    (bus_in_data),
    .bus_out        (bus_out),
    .bus_we         (bus_we),
    .bus_re_data    (bus_re_data),
    .current_opcode (current_opcode)
  );

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    stop_on_error($sformatf("FAIL at %0t: %s expected %h, got %h", $time, name, exp, got));
  endtask

  // Records are tokens and several may share a line
  task automatic load_tests();
    int fd;
    int rc;
    int n;
    logic [7:0]       kind;
    logic [31:0]      a;
    logic [31:0]      v;
    logic [8*160-1:0] rest;
    fd = $fopen("tb/cpu_tests.txt", "r");
    assert (fd != 0) else stop_on_error("could not open tb/cpu_tests.txt");
    while ($fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "P": begin
          rc = $fscanf(fd, "%h %h", a, n);
          assert (rc == 2) else stop_on_error("malformed P record in test file");
          repeat (n) begin
            rc = $fscanf(fd, "%h", v);
            assert (rc == 1) else stop_on_error("missing program byte in test file");
            imem[a[7:0]] = v[7:0];
            a = a + 1;
            prog_bytes++;
          end
        end
        "D": begin
          rc = $fscanf(fd, "%h %h", a, v);
          assert (rc == 2) else stop_on_error("malformed D record in test file");
          dmem[a] = v;
        end
        "L": begin
          rc = $fscanf(fd, "%h", a);
          assert (rc == 1) else stop_on_error("malformed L record in test file");
          exp_ld.push_back(a);
        end
        "S": begin
          rc = $fscanf(fd, "%h %h", a, v);
          assert (rc == 2) else stop_on_error("malformed S record in test file");
          exp_st_a.push_back(a);
          exp_st_v.push_back(v);
        end
        "A": begin
          rc = $fscanf(fd, "%h", a);
          assert (rc == 1) else stop_on_error("malformed A record in test file");
          exp_ia.push_back(a);
        end
        // Rest of the line is a comment
        "#": rc = $fgets(rest, fd);
        default: stop_on_error($sformatf("unknown record type %c in test file", kind));
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Both memories answer off this cycle's addresses
  always @(posedge clk) begin
    #2;
    // Little endian with the opcode in the low byte
    bus_in_ins = {imem[bus_a_ins[7:0] + 8'd3], imem[bus_a_ins[7:0] + 8'd2],
                  imem[bus_a_ins[7:0] + 8'd1], imem[bus_a_ins[7:0]]};
    bus_in_data = dmem.exists(bus_a_data) ? dmem[bus_a_data] : bus_a_data ^ 32'hA5A5_5A5A;
  end

  always @(negedge clk) begin
    cycles++;
    assert (cycles <= limit) else stop_on_error("timeout, halt never reached write-back");
    // Quiet outputs in reset and the first free cycle
    if (cycles <= RST_CYCLES) begin
      assert (bus_we === 1'b0) else report_mismatch("bus_we", 0, bus_we);
      assert (bus_re_data === 1'b0) else report_mismatch("bus_re_data", 0, bus_re_data);
      assert (current_opcode === 8'h00)
        else report_mismatch("current_opcode", 0, current_opcode);
      assert (bus_a_ins === 32'h0) else report_mismatch("bus_a_ins", 0, bus_a_ins);
    end
    // Every new fetch address is the next in the trace
    if (ai == 0 || bus_a_ins !== last_ia) begin
      assert (ai < exp_ia.size()) else stop_on_error("instruction pointer moved past the halt");
      assert (bus_a_ins === exp_ia[ai]) else report_mismatch("bus_a_ins", exp_ia[ai], bus_a_ins);
      last_ia = bus_a_ins;
      ai++;
    end
    // Load address is esi plus displacement
    if (bus_re_data === 1'b1) begin
      assert (li < exp_ld.size()) else stop_on_error("more loads than expected");
      assert (bus_a_data === exp_ld[li])
        else report_mismatch("bus_a_data", exp_ld[li], bus_a_data);
      li++;
    end
    // Stores in program order update the memory model
    if (bus_we === 1'b1) begin
      assert (si < exp_st_a.size()) else stop_on_error("store seen after the last expected one");
      assert (bus_a_data === exp_st_a[si])
        else report_mismatch("bus_a_data", exp_st_a[si], bus_a_data);
      assert (bus_out === exp_st_v[si]) else report_mismatch("bus_out", exp_st_v[si], bus_out);
      dmem[bus_a_data] = bus_out;
      si++;
    end
    if (halted)
      assert (current_opcode === 8'hF4)
        else report_mismatch("current_opcode", 32'hF4, current_opcode);
  end

  initial begin
    rst = 1'b1;
    bus_in_ins = '0;
    bus_in_data = '0;
    halted = 1'b0;
    load_tests();
    // Whole program plus pipeline drain
    limit = 2 * prog_bytes + 20;
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst = 1'b0;
    // Halt in write-back ends the program
    while (current_opcode !== 8'hF4)
      @(negedge clk);
    halted = 1'b1;
    // Pipe should stay parked on halt
    repeat (8) @(negedge clk);
    @(posedge clk);
    assert (si == exp_st_a.size()) else report_mismatch("store count", exp_st_a.size(), si);
    assert (li == exp_ld.size()) else report_mismatch("load count", exp_ld.size(), li);
    assert (ai == exp_ia.size()) else report_mismatch("fetch count", exp_ia.size(), ai);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== tb/cpu_tests.txt ====
# Records: P addr count bytes, D addr word, L load addr, S store addr value, A fetch addr
# All fields hex, records may share a line, a hash starts a comment to the end of the line
P 00 08 8B 40 40 8B 48 44 90 90  # load eax from esi+40, load ecx from esi+44, padding
P 08 07 01 C8 90 90 89 40 50  # add eax ecx, store eax to esi+50
P 0F 06 29 C8 89 CA 90 90  # sub eax ecx, move edx from ecx
P 15 06 89 40 54 89 50 58  # store eax to esi+54 and edx to esi+58
P 1B 08 8B 58 48 90 90 89 58 5C  # load ebx from esi+48 and copy it to esi+5C
P 23 0C 83 C3 83 EA 90 90 89 58 60 89 50 64  # ebx plus 10, edx minus 10, store both
P 2F 04 F4 90 90 90  # halt
D 40 00001234 D 44 00000F0F D 48 800000AA
L 40 L 44 L 48
S 50 00002143 S 54 00001234 S 58 00000F0F
S 5C 800000AA S 60 800000B4 S 64 00000F05
A 00 A 03 A 06 A 07 A 08 A 0A A 0B A 0C A 0F A 11 A 13 A 14 A 15
A 18 A 1B A 1E A 1F A 20 A 23 A 25 A 27 A 28 A 29 A 2C A 2F

// ==== build.f ====
+incdir+source
source/cpu_pkg.sv
source/cpu_ifs.sv
source/instr_decoder.sv
source/fetch_unit.sv
source/register_file.sv
source/execute_unit.sv
source/mem_wb_unit.sv
source/cisc_cpu_top.sv
tb/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cisc_cpu

sources:
  - include_dirs:
      - source
    files:
      - source/cpu_pkg.sv
      - source/cpu_ifs.sv
      - source/instr_decoder.sv
      - source/fetch_unit.sv
      - source/register_file.sv
      - source/execute_unit.sv
      - source/mem_wb_unit.sv
      - source/cisc_cpu_top.sv
  - target: test
    files:
      - tb/cpu_tb.sv
